/* dv/dr_gth_drp_tb.sv */
// Runs the top level with default parameters only; LCG seed is fixed, addresses avoid STATUS_ADDR
`timescale 1ns/100ps

module dr_gth_drp_tb;

  ////////////////////////////////////////////////////////////////////////////
  // Parameters and stimulus sizing
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned DRP_LATENCY = 4;
  localparam int unsigned HOLDOFF     = 16;
  localparam int unsigned POLL_PERIOD = 64;

  localparam int unsigned N_WORDS   = 16;
  // Writes, two rounds of read-backs, status accesses and the held trigger
  localparam int unsigned N_OPS     = 3 * N_WORDS + 12;
  localparam int unsigned RDY_WAIT  = 2 * (DRP_LATENCY + 2) + 8;
  localparam int unsigned IDLE_POLL = POLL_PERIOD + 2 * (DRP_LATENCY + 2);
  localparam int unsigned WATCHDOG  = N_OPS * 200 + 2000;

  logic                           FREEDRPCLK_i;
  logic                           rx_wordclk;
  logic                           drp_rst_i;
  logic                           drp_trigger_i;
  logic [drp_pkg::DRP_ADDR_W-1:0] drp_addr_i;
  logic [drp_pkg::DRP_DATA_W-1:0] drp_di_i;
  logic                           drp_we_i;
  logic [drp_pkg::DRP_DATA_W-1:0] drp_do_o;
  logic                           drp_rdy_o;
  logic [drp_pkg::DRP_DATA_W-1:0] dmonitor_data_o;

  int unsigned value_errors;
  int unsigned check_fails;
  int unsigned rdy_count;
  logic [31:0] rng_state;

  // Reference model
  logic [drp_pkg::DRP_DATA_W-1:0] shadow_mem [512];
  logic [drp_pkg::WCOUNT_W-1:0]   shadow_wcount;
  logic [drp_pkg::DRP_ADDR_W-1:0] addr_list [N_WORDS];

  dr_gth_drp_top #(
    .DRP_LATENCY (DRP_LATENCY),
    .HOLDOFF     (HOLDOFF),
    .POLL_PERIOD (POLL_PERIOD)
  ) uut (
    .FREEDRPCLK_i    (FREEDRPCLK_i),
    .rx_wordclk      (rx_wordclk),
    .drp_rst_i       (drp_rst_i),
    .drp_trigger_i   (drp_trigger_i),
    .drp_addr_i      (drp_addr_i),
    .drp_di_i        (drp_di_i),
    .drp_we_i        (drp_we_i),
    .drp_do_o        (drp_do_o),
    .drp_rdy_o       (drp_rdy_o),
    .dmonitor_data_o (dmonitor_data_o)
  );

  // 4 ns DRP clock
  initial begin
    FREEDRPCLK_i = 1'b0;
    forever #2 FREEDRPCLK_i = ~FREEDRPCLK_i;
  end

  // Completions counted midway through the cycle
  always @(negedge FREEDRPCLK_i) begin
    if (drp_rdy_o) begin
      rdy_count++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Concurrent checks
  ////////////////////////////////////////////////////////////////////////////

  // Quiet outputs during reset and on the first cycle after it
  a_quiet_in_reset: assert property (
    @(posedge FREEDRPCLK_i) $past(rx_wordclk) |-> (!drp_rdy_o && dmonitor_data_o == '0)
  ) else begin
    value_errors++;
    $display("error %0t ns: drp_rdy_o or dmonitor_data_o was active in reset", $time);
  end

  a_rdy_one_cycle: assert property (
    @(posedge FREEDRPCLK_i) disable iff (rx_wordclk) drp_rdy_o |=> !drp_rdy_o
  ) else begin
    check_fails++;
    $display("drp_rdy_o stayed high for more than one cycle at %0t", $time);
  end

  // Any captured status word carries the alive bit
  a_monitor_alive: assert property (
    @(posedge FREEDRPCLK_i) disable iff (rx_wordclk)
    (dmonitor_data_o != '0) |-> dmonitor_data_o[0]
  ) else begin
    value_errors++;
    $display("error %0t ns: dmonitor_data_o is %h without the alive bit",
             $time, dmonitor_data_o);
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Status slot reads the write count over a fixed one
  function automatic logic [15:0] expected_word(input logic [8:0] addr);
    if (addr == drp_pkg::STATUS_ADDR) begin
      return {shadow_wcount, 1'b1};
    end else begin
      return shadow_mem[addr];
    end
  endfunction

  // Lands 1 ns after a rising edge
  task automatic wait_cycles(input int unsigned n);
    repeat (n) begin
      @(posedge FREEDRPCLK_i);
      #1;
    end
  endtask

  // Raise the trigger, hold fields until drp_rdy_o, drop it well inside HOLDOFF
  task automatic host_op(input logic we, input logic [8:0] addr, input logic [15:0] di,
                         output logic [15:0] rdata);
    int unsigned start_cnt;
    int unsigned waited;
    logic        seen;
    start_cnt     = rdy_count;
    seen          = 1'b0;
    waited        = 0;
    rdata         = '0;
    drp_addr_i    = addr;
    drp_di_i      = di;
    drp_we_i      = we;
    drp_trigger_i = 1'b1;
    while (!seen && waited < RDY_WAIT) begin
      wait_cycles(1);
      waited++;
      if (drp_rdy_o) begin
        seen  = 1'b1;
        rdata = drp_do_o;
      end
    end
    drp_trigger_i = 1'b0;
    if (!seen) begin
      check_fails++;
      $display("no drp_rdy_o within %0d cycles for addr %h at %0t", RDY_WAIT, addr, $time);
    end
    // Let the low level reach the holdoff counter
    wait_cycles(4);
    assert (rdy_count == start_cnt + 1) else begin
      value_errors++;
      $display("error %0t ns: trigger for addr %h gave %0d drp_rdy_o pulses, expected 1",
               $time, addr, rdy_count - start_cnt);
    end
  endtask

  // Status writes are dropped but counted
  task automatic write_word(input logic [8:0] addr, input logic [15:0] data);
    logic [15:0] unused_rd;
    host_op(1'b1, addr, data, unused_rd);
    if (addr != drp_pkg::STATUS_ADDR) begin
      shadow_mem[addr] = data;
    end
    shadow_wcount = shadow_wcount + 15'd1;
  endtask

  task automatic read_check(input logic [8:0] addr);
    logic [15:0] got;
    logic [15:0] exp;
    exp = expected_word(addr);
    host_op(1'b0, addr, 16'h0000, got);
    assert (got == exp) else begin
      value_errors++;
      $display("error %0t ns: read of addr %h returned %h, expected %h",
               $time, addr, got, exp);
    end
  endtask

  // Idle long enough for a full poll after the last write
  task automatic check_monitor();
    wait_cycles(IDLE_POLL);
    assert (dmonitor_data_o == expected_word(drp_pkg::STATUS_ADDR)) else begin
      value_errors++;
      $display("error %0t ns: dmonitor_data_o is %h, expected %h",
               $time, dmonitor_data_o, expected_word(drp_pkg::STATUS_ADDR));
    end
  endtask

  task automatic clear_shadow();
    for (int i = 0; i < 512; i++) begin
      shadow_mem[i] = '0;
    end
    shadow_wcount = '0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin : watchdog
    repeat (WATCHDOG) @(posedge FREEDRPCLK_i);
    $display("run did not finish within %0d cycles", WATCHDOG);
    $display("sim failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main
    logic [8:0]  a;
    int unsigned held_start;
    value_errors  = 0;
    check_fails   = 0;
    rdy_count     = 0;
    rng_state     = 32'h0512_d850;
    rx_wordclk    = 1'b1;
    // drp_rst_i also wipes the attribute memory while in reset
    drp_rst_i     = 1'b1;
    drp_trigger_i = 1'b0;
    drp_addr_i    = '0;
    drp_di_i      = '0;
    drp_we_i      = 1'b0;
    clear_shadow();
    repeat (16) @(posedge FREEDRPCLK_i);
    #1;
    rx_wordclk = 1'b0;
    drp_rst_i  = 1'b0;
    wait_cycles(4);

    // Random writes, then one into the status slot
    for (int i = 0; i < N_WORDS; i++) begin
      rng_state = lcg_next(rng_state);
      a         = rng_state[31:23];
      if (a == drp_pkg::STATUS_ADDR) begin
        a = '0;
      end
      addr_list[i] = a;
      rng_state    = lcg_next(rng_state);
      write_word(a, rng_state[31:16]);
    end
    write_word(drp_pkg::STATUS_ADDR, 16'hdead);

    // Read back plus status word
    for (int i = 0; i < N_WORDS; i++) begin
      read_check(addr_list[i]);
    end
    read_check(drp_pkg::STATUS_ADDR);
    check_monitor();

    // Trigger held for three holdoff periods re-fires three times
    held_start    = rdy_count;
    drp_addr_i    = addr_list[0];
    drp_we_i      = 1'b0;
    drp_trigger_i = 1'b1;
    wait_cycles(3 * HOLDOFF);
    drp_trigger_i = 1'b0;
    wait_cycles(HOLDOFF + 2 * (DRP_LATENCY + 2));
    assert (rdy_count - held_start == 3) else begin
      value_errors++;
      $display("error %0t ns: held trigger gave %0d drp_rdy_o pulses, expected 3",
               $time, rdy_count - held_start);
    end

    // Attribute reset clears memory and write count
    drp_rst_i = 1'b1;
    wait_cycles(3);
    drp_rst_i = 1'b0;
    clear_shadow();
    wait_cycles(1);
    for (int i = 0; i < N_WORDS; i++) begin
      read_check(addr_list[i]);
    end
    read_check(drp_pkg::STATUS_ADDR);
    check_monitor();

    $display("value errors: %0d, other failures: %0d", value_errors, check_fails);
    if (value_errors == 0 && check_fails == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* files.f */
logic/drp_pkg.sv
logic/drp_trigger_gen.sv
logic/drp_monitor_poll.sv
logic/drp_arbiter.sv
logic/drp_attr_regs.sv
logic/dr_gth_drp_top.sv
dv/dr_gth_drp_tb.sv

/* logic/dr_gth_drp_top.sv */
// DRP side of the receive wrapper only; host fields must hold from trigger rise until drp_rdy_o
`timescale 1ns/100ps

module dr_gth_drp_top #(
  parameter int unsigned DRP_LATENCY = 4,
  parameter int unsigned HOLDOFF     = 16,
  parameter int unsigned POLL_PERIOD = 64
) (
  input  logic                           FREEDRPCLK_i,
  input  logic                           rx_wordclk,
  input  logic                           drp_rst_i,
  input  logic                           drp_trigger_i,
  input  logic [drp_pkg::DRP_ADDR_W-1:0] drp_addr_i,
  input  logic [drp_pkg::DRP_DATA_W-1:0] drp_di_i,
  input  logic                           drp_we_i,
  output logic [drp_pkg::DRP_DATA_W-1:0] drp_do_o,
  output logic                           drp_rdy_o,
  output logic [drp_pkg::DRP_DATA_W-1:0] dmonitor_data_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Parameter check
  ////////////////////////////////////////////////////////////////////////////

  // Worst case host turnaround must finish before the next re-fire
  if (HOLDOFF <= 2 * (DRP_LATENCY + 2)) begin : g_holdoff_check
    $error("HOLDOFF must exceed 2*(DRP_LATENCY+2)");
  end

  logic                           host_req;
  logic                           mon_req;
  logic [drp_pkg::DRP_ADDR_W-1:0] mon_addr;
  logic                           mon_done;
  logic [drp_pkg::DRP_DATA_W-1:0] mon_data;

  logic                           bus_en;
  logic                           bus_we;
  logic [drp_pkg::DRP_ADDR_W-1:0] bus_addr;
  logic [drp_pkg::DRP_DATA_W-1:0] bus_di;
  logic                           bus_rdy;
  logic [drp_pkg::DRP_DATA_W-1:0] bus_do;

  // Host trigger level to request pulses
  drp_trigger_gen #(
    .HOLDOFF (HOLDOFF)
  ) u_trigger_gen (
    .FREEDRPCLK_i  (FREEDRPCLK_i),
    .rx_wordclk    (rx_wordclk),
    .drp_trigger_i (drp_trigger_i),
    .host_req_o    (host_req)
  );

  // Periodic status reads for debug
  drp_monitor_poll #(
    .POLL_PERIOD (POLL_PERIOD),
    .MON_ADDR    (drp_pkg::STATUS_ADDR)
  ) u_monitor_poll (
    .FREEDRPCLK_i    (FREEDRPCLK_i),
    .rx_wordclk      (rx_wordclk),
    .mon_req_o       (mon_req),
    .mon_addr_o      (mon_addr),
    .mon_done_i      (mon_done),
    .mon_data_i      (mon_data),
    .dmonitor_data_o (dmonitor_data_o)
  );

  drp_arbiter u_arbiter (
    .FREEDRPCLK_i (FREEDRPCLK_i),
    .rx_wordclk   (rx_wordclk),
    .host_req_i   (host_req),
    .host_addr_i  (drp_addr_i),
    .host_di_i    (drp_di_i),
    .host_we_i    (drp_we_i),
    .host_done_o  (drp_rdy_o),
    .host_do_o    (drp_do_o),
    .mon_req_i    (mon_req),
    .mon_addr_i   (mon_addr),
    .mon_done_o   (mon_done),
    .mon_do_o     (mon_data),
    .bus_en_o     (bus_en),
    .bus_we_o     (bus_we),
    .bus_addr_o   (bus_addr),
    .bus_di_o     (bus_di),
    .bus_rdy_i    (bus_rdy),
    .bus_do_i     (bus_do)
  );

  // Stands in for the transceiver channel attributes
  drp_attr_regs #(
    .DRP_LATENCY (DRP_LATENCY)
  ) u_attr_regs (
    .FREEDRPCLK_i (FREEDRPCLK_i),
    .rx_wordclk   (rx_wordclk),
    .drp_rst_i    (drp_rst_i),
    .drp_en_i     (bus_en),
    .drp_we_i     (bus_we),
    .drp_addr_i   (bus_addr),
    .drp_di_i     (bus_di),
    .drp_do_o     (bus_do),
    .drp_rdy_o    (bus_rdy)
  );

endmodule

/* logic/drp_arbiter.sv */
// Two-peer round-robin DRP arbiter; one transaction outstanding, requests are single-cycle pulses
`timescale 1ns/100ps

module drp_arbiter (
  input  logic                           FREEDRPCLK_i,
  input  logic                           rx_wordclk,
  // Host peer
  input  logic                           host_req_i,
  input  logic [drp_pkg::DRP_ADDR_W-1:0] host_addr_i,
  input  logic [drp_pkg::DRP_DATA_W-1:0] host_di_i,
  input  logic                           host_we_i,
  output logic                           host_done_o,
  output logic [drp_pkg::DRP_DATA_W-1:0] host_do_o,
  // Monitor peer, read only
  input  logic                           mon_req_i,
  input  logic [drp_pkg::DRP_ADDR_W-1:0] mon_addr_i,
  output logic                           mon_done_o,
  output logic [drp_pkg::DRP_DATA_W-1:0] mon_do_o,
  // Shared DRP bus
  output logic                           bus_en_o,
  output logic                           bus_we_o,
  output logic [drp_pkg::DRP_ADDR_W-1:0] bus_addr_o,
  output logic [drp_pkg::DRP_DATA_W-1:0] bus_di_o,
  input  logic                           bus_rdy_i,
  input  logic [drp_pkg::DRP_DATA_W-1:0] bus_do_i
);

  // Pending latches and their fields
  logic                           pend_host;
  logic                           pend_mon;
  logic [drp_pkg::DRP_ADDR_W-1:0] host_addr_q;
  logic [drp_pkg::DRP_DATA_W-1:0] host_di_q;
  logic                           host_we_q;
  logic [drp_pkg::DRP_ADDR_W-1:0] mon_addr_q;

  // Bus ownership
  logic busy;
  logic owner;
  logic last_src;

  logic grant;
  logic grant_src;

  ////////////////////////////////////////////////////////////////////////////
  // Grant decision
  ////////////////////////////////////////////////////////////////////////////

  assign grant = !busy && (pend_host || pend_mon);

  // Both pending: serve whoever went second last time
  always_comb begin
    if (pend_host && pend_mon) begin
      grant_src = ~last_src;
    end else if (pend_mon) begin
      grant_src = drp_pkg::SRC_MON;
    end else begin
      grant_src = drp_pkg::SRC_HOST;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pending latches
  ////////////////////////////////////////////////////////////////////////////

  // A new request wins over the clear from a grant in the same cycle
  always_ff @(posedge FREEDRPCLK_i or posedge rx_wordclk) begin
    if (rx_wordclk) begin
      pend_host <= 1'b0;
      pend_mon  <= 1'b0;
    end else begin
      if (grant && grant_src == drp_pkg::SRC_HOST) begin
        pend_host <= 1'b0;
      end
      if (grant && grant_src == drp_pkg::SRC_MON) begin
        pend_mon <= 1'b0;
      end
      if (host_req_i) begin
        pend_host <= 1'b1;
      end
      if (mon_req_i) begin
        pend_mon <= 1'b1;
      end
    end
  end

  // Request fields, sampled with the pulse
  always_ff @(posedge FREEDRPCLK_i) begin
    if (host_req_i) begin
      host_addr_q <= host_addr_i;
      host_di_q   <= host_di_i;
      host_we_q   <= host_we_i;
    end
    if (mon_req_i) begin
      mon_addr_q <= mon_addr_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bus cycle and completion
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge FREEDRPCLK_i or posedge rx_wordclk) begin
    if (rx_wordclk) begin
      bus_en_o    <= 1'b0;
      bus_we_o    <= 1'b0;
      busy        <= 1'b0;
      owner       <= drp_pkg::SRC_HOST;
      last_src    <= drp_pkg::SRC_MON;
      host_done_o <= 1'b0;
      mon_done_o  <= 1'b0;
    end else begin
      bus_en_o    <= grant;
      bus_we_o    <= grant && grant_src == drp_pkg::SRC_HOST && host_we_q;
      host_done_o <= bus_rdy_i && owner == drp_pkg::SRC_HOST;
      mon_done_o  <= bus_rdy_i && owner == drp_pkg::SRC_MON;
      if (grant) begin
        busy     <= 1'b1;
        owner    <= grant_src;
        last_src <= grant_src;
      end else if (bus_rdy_i) begin
        busy <= 1'b0;
      end
    end
  end

  // Payload side, monitor always reads
  always_ff @(posedge FREEDRPCLK_i) begin
    if (grant) begin
      bus_addr_o <= (grant_src == drp_pkg::SRC_HOST) ? host_addr_q : mon_addr_q;
      bus_di_o   <= (grant_src == drp_pkg::SRC_HOST) ? host_di_q : '0;
    end
    if (bus_rdy_i) begin
      host_do_o <= bus_do_i;
      mon_do_o  <= bus_do_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  a_rdy_only_busy: assert property (
    @(posedge FREEDRPCLK_i) disable iff (rx_wordclk)
    bus_rdy_i |-> busy
  );

  a_host_not_twice: assert property (
    @(posedge FREEDRPCLK_i) disable iff (rx_wordclk)
    host_req_i |-> !pend_host
  );

  a_mon_not_twice: assert property (
    @(posedge FREEDRPCLK_i) disable iff (rx_wordclk)
    mon_req_i |-> !pend_mon
  );

  // An enable may only leave an idle bus, never beside a ready
  a_en_from_idle: assert property (
    @(posedge FREEDRPCLK_i) disable iff (rx_wordclk)
    bus_en_o |-> !bus_rdy_i
  );

endmodule

/* logic/drp_attr_regs.sv */
// Behavioral stand-in for transceiver attributes; fixed latency, DRP_LATENCY at least 1, no overlap
`timescale 1ns/100ps

module drp_attr_regs #(
  parameter int unsigned DRP_LATENCY = 4
) (
  input  logic                           FREEDRPCLK_i,
  input  logic                           rx_wordclk,
  input  logic                           drp_rst_i,
  input  logic                           drp_en_i,
  input  logic                           drp_we_i,
  input  logic [drp_pkg::DRP_ADDR_W-1:0] drp_addr_i,
  input  logic [drp_pkg::DRP_DATA_W-1:0] drp_di_i,
  output logic [drp_pkg::DRP_DATA_W-1:0] drp_do_o,
  output logic                           drp_rdy_o
);

  localparam int unsigned DEPTH = 1 << drp_pkg::DRP_ADDR_W;

  logic [drp_pkg::DRP_DATA_W-1:0] attr_mem [DEPTH];

  // Latency pipeline, one slot per cycle
  logic                           en_pipe   [DRP_LATENCY];
  logic                           we_pipe   [DRP_LATENCY];
  logic [drp_pkg::DRP_ADDR_W-1:0] addr_pipe [DRP_LATENCY];
  logic [drp_pkg::DRP_DATA_W-1:0] di_pipe   [DRP_LATENCY];

  logic [drp_pkg::WCOUNT_W-1:0]   wr_count;
  logic                           commit;
  logic [drp_pkg::DRP_ADDR_W-1:0] last_addr;

  assign last_addr = addr_pipe[DRP_LATENCY-1];
  assign drp_rdy_o = en_pipe[DRP_LATENCY-1];
  assign commit    = drp_rdy_o && we_pipe[DRP_LATENCY-1];

  // Status word is live, memory read otherwise
  assign drp_do_o = (last_addr == drp_pkg::STATUS_ADDR) ?
                    {wr_count, drp_pkg::STATUS_ALIVE} : attr_mem[last_addr];

  ////////////////////////////////////////////////////////////////////////////
  // Latency pipeline
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge FREEDRPCLK_i or posedge rx_wordclk) begin
    if (rx_wordclk) begin
      for (int i = 0; i < DRP_LATENCY; i++) begin
        en_pipe[i] <= 1'b0;
      end
    end else begin
      en_pipe[0] <= drp_en_i;
      for (int i = 1; i < DRP_LATENCY; i++) begin
        en_pipe[i] <= en_pipe[i-1];
      end
    end
  end

  always_ff @(posedge FREEDRPCLK_i) begin
    we_pipe[0]   <= drp_we_i;
    addr_pipe[0] <= drp_addr_i;
    di_pipe[0]   <= drp_di_i;
    for (int i = 1; i < DRP_LATENCY; i++) begin
      we_pipe[i]   <= we_pipe[i-1];
      addr_pipe[i] <= addr_pipe[i-1];
      di_pipe[i]   <= di_pipe[i-1];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Attribute storage and write count
  ////////////////////////////////////////////////////////////////////////////

  // drp_rst_i wipes the whole space, takes priority over a commit
  always_ff @(posedge FREEDRPCLK_i) begin
    if (drp_rst_i) begin
      for (int i = 0; i < DEPTH; i++) begin
        attr_mem[i] <= '0;
      end
    end else if (commit && last_addr != drp_pkg::STATUS_ADDR) begin
      attr_mem[last_addr] <= di_pipe[DRP_LATENCY-1];
    end
  end

  // Status writes are dropped but still counted, wraps at 2^15
  always_ff @(posedge FREEDRPCLK_i or posedge rx_wordclk) begin
    if (rx_wordclk) begin
      wr_count <= '0;
    end else if (drp_rst_i) begin
      wr_count <= '0;
    end else if (commit) begin
      wr_count <= wr_count + 1'b1;
    end
  end

endmodule

/* logic/drp_monitor_poll.sv */
// Polls one fixed address every POLL_PERIOD cycles; skips a poll while the previous one is open
`timescale 1ns/100ps

module drp_monitor_poll #(
  parameter int unsigned                        POLL_PERIOD = 64,
  parameter logic [drp_pkg::DRP_ADDR_W-1:0]     MON_ADDR    = drp_pkg::STATUS_ADDR
) (
  input  logic                           FREEDRPCLK_i,
  input  logic                           rx_wordclk,
  output logic                           mon_req_o,
  output logic [drp_pkg::DRP_ADDR_W-1:0] mon_addr_o,
  input  logic                           mon_done_i,
  input  logic [drp_pkg::DRP_DATA_W-1:0] mon_data_i,
  output logic [drp_pkg::DRP_DATA_W-1:0] dmonitor_data_o
);

  localparam int unsigned CNT_W = (POLL_PERIOD > 1) ? $clog2(POLL_PERIOD) : 1;

  logic [CNT_W-1:0] poll_cnt;
  logic             outstanding;
  logic             fire;

  // Address never changes, it is a debug tap
  assign mon_addr_o = MON_ADDR;

  // Interval elapsed and the bus has answered the last poll
  assign fire = (poll_cnt == '0) && !outstanding;

  ////////////////////////////////////////////////////////////////////////////
  // Interval counter
  ////////////////////////////////////////////////////////////////////////////

  // Counts down from POLL_PERIOD-1, holds at zero while a read is open
  always_ff @(posedge FREEDRPCLK_i or posedge rx_wordclk) begin
    if (rx_wordclk) begin
      poll_cnt  <= CNT_W'(POLL_PERIOD - 1);
      mon_req_o <= 1'b0;
    end else if (fire) begin
      poll_cnt  <= CNT_W'(POLL_PERIOD - 1);
      mon_req_o <= 1'b1;
    end else begin
      mon_req_o <= 1'b0;
      if (poll_cnt != '0) begin
        poll_cnt <= poll_cnt - 1'b1;
      end
    end
  end

  // Open from the request until the arbiter hands back the data
  always_ff @(posedge FREEDRPCLK_i or posedge rx_wordclk) begin
    if (rx_wordclk) begin
      outstanding <= 1'b0;
    end else if (fire) begin
      outstanding <= 1'b1;
    end else if (mon_done_i) begin
      outstanding <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Capture register
  ////////////////////////////////////////////////////////////////////////////

  // Last status word, visible without a host transaction
  // Cleared by reset so software never sees a stale value
  always_ff @(posedge FREEDRPCLK_i or posedge rx_wordclk) begin
    if (rx_wordclk) begin
      dmonitor_data_o <= '0;
    end else if (mon_done_i) begin
      dmonitor_data_o <= mon_data_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Arbiter must route only our own completions here
  a_done_after_req: assert property (
    @(posedge FREEDRPCLK_i) disable iff (rx_wordclk)
    mon_done_i |-> outstanding
  );

endmodule

/* logic/drp_pkg.sv */
// Shared DRP widths, source IDs and reserved addresses; STATUS_ADDR assumes a 9-bit address space
package drp_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus geometry
  ////////////////////////////////////////////////////////////////////////////

  // 9-bit address, 512 attribute words
  localparam int unsigned DRP_ADDR_W = 9;

  // One DRP word
  localparam int unsigned DRP_DATA_W = 16;

  // Write counter occupies bits 15..1 of the status word
  localparam int unsigned WCOUNT_W = DRP_DATA_W - 1;

  ////////////////////////////////////////////////////////////////////////////
  // Source identifiers
  ////////////////////////////////////////////////////////////////////////////

  // Host and monitor are complements of each other
  // The arbiter relies on this to flip its round-robin pointer
  localparam logic SRC_HOST = 1'b0;
  localparam logic SRC_MON  = 1'b1;

  ////////////////////////////////////////////////////////////////////////////
  // Reserved addresses
  ////////////////////////////////////////////////////////////////////////////

  // Read-only status word at the top of the space
  // Bit 0 reads one, bits 15..1 count completed writes
  localparam logic [DRP_ADDR_W-1:0] STATUS_ADDR = 9'h1FF;

  // Fixed low bit of the status word
  localparam logic STATUS_ALIVE = 1'b1;

endpackage

/* logic/drp_trigger_gen.sv */
// Trigger level is async to FREEDRPCLK_i; HOLDOFF must be at least 2, one pulse per HOLDOFF cycles
`timescale 1ns/100ps

module drp_trigger_gen #(
  parameter int unsigned HOLDOFF = 16
) (
  input  logic FREEDRPCLK_i,
  input  logic rx_wordclk,
  input  logic drp_trigger_i,
  output logic host_req_o
);

  // Counter just wide enough for HOLDOFF-1
  localparam int unsigned CNT_W = (HOLDOFF > 1) ? $clog2(HOLDOFF) : 1;

  logic             trig_meta;
  logic             trig_sync;
  logic [CNT_W-1:0] holdoff_cnt;

  ////////////////////////////////////////////////////////////////////////////
  // Two-flop synchronizer
  ////////////////////////////////////////////////////////////////////////////

  // First stage may go metastable, second stage is the one we use
  always_ff @(posedge FREEDRPCLK_i or posedge rx_wordclk) begin
    if (rx_wordclk) begin
      trig_meta <= 1'b0;
      trig_sync <= 1'b0;
    end else begin
      trig_meta <= drp_trigger_i;
      trig_sync <= trig_meta;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Holdoff counter
  ////////////////////////////////////////////////////////////////////////////

  // Fire once when the count is zero, then wait HOLDOFF cycles
  // A dropped trigger clears the count so the next rise fires at once
  always_ff @(posedge FREEDRPCLK_i or posedge rx_wordclk) begin
    if (rx_wordclk) begin
      host_req_o  <= 1'b0;
      holdoff_cnt <= '0;
    end else if (!trig_sync) begin
      host_req_o  <= 1'b0;
      holdoff_cnt <= '0;
    end else if (holdoff_cnt == '0) begin
      host_req_o  <= 1'b1;
      holdoff_cnt <= CNT_W'(HOLDOFF - 1);
    end else begin
      host_req_o  <= 1'b0;
      holdoff_cnt <= holdoff_cnt - 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // A held trigger must never produce back-to-back requests
  a_single_cycle_req: assert property (
    @(posedge FREEDRPCLK_i) disable iff (rx_wordclk)
    host_req_o |=> !host_req_o
  );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f files.f --top-module dr_gth_drp_tb -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "sim failed" sim.log; then
  exit 1
fi
if ! grep -q "sim passed" sim.log; then
  echo "simulation ended without a pass message"
  exit 1
fi
exit 0
